/* sources.f */
+incdir+include
hw/conv_pkg.sv
hw/axis_stream_if.sv
hw/conv_weight_store.sv
hw/axis_shift_buffer.sv
hw/conv_mac_array.sv
hw/conv_row_engine.sv
sim/tb_conv_row_engine.sv

/* Makefile */
TOP = tb_conv_row_engine

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* include/conv_tb_model.svh */
`ifndef CONV_TB_MODEL_SVH
`define CONV_TB_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'd94650;
localparam logic [31:0] LFSR_MASK = 32'hB4BC_D35C;  // Maximal length, right shifting

logic [31:0] lfsr_state = LFSR_SEED;
sample_t     w_model    [CHANNELS][DEPTH];  // Mirror of the weight store
vector_t     group_vecs [CHANNELS];         // One vector per channel of a group

// Galois LFSR, one step per bit taken
function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] bits;
    logic        out_bit;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_MASK;
        end
        bits = {bits[62:0], out_bit};
    end
    return bits;
endfunction

function automatic vector_t random_vector();
    vector_t     v;
    logic [63:0] bits;
    for (int j = 0; j < WORDS; j++) begin
        bits = lfsr_bits(DATA_WIDTH);
        v[j*DATA_WIDTH +: DATA_WIDTH] = bits[DATA_WIDTH-1:0];
    end
    return v;
endfunction

function automatic sample_t sample_at(input vector_t v, input int idx);
    return v[idx*DATA_WIDTH +: DATA_WIDTH];
endfunction

// Lane i gets the sum of w[c][k] * x_c[i+k], kept to its low ACC_WIDTH bits
function automatic result_t expected_result(input int channels);
    result_t r;
    longint  sum;
    longint  w;
    longint  x;
    for (int i = 0; i < CONV_UNITS; i++) begin
        sum = 0;
        for (int c = 0; c < channels; c++) begin
            for (int k = 0; k < DEPTH; k++) begin
                w   = w_model[c][k];                // Sign extended
                x   = sample_at(group_vecs[c], i + k);
                sum = sum + w * x;
            end
        end
        r[i*ACC_WIDTH +: ACC_WIDTH] = sum[ACC_WIDTH-1:0];
    end
    return r;
endfunction

task automatic check_result(input string name, input result_t got, input result_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
        error_count++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
        error_count++;
    end
endtask

`endif

/* sim/tb_conv_row_engine.sv */
`default_nettype none

module tb_conv_row_engine;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH   = conv_pkg::DEF_DATA_WIDTH;
    localparam int CONV_UNITS   = conv_pkg::DEF_CONV_UNITS;
    localparam int DEPTH        = conv_pkg::DEF_DEPTH;
    localparam int CH_WIDTH     = conv_pkg::DEF_CH_WIDTH;
    localparam int CNT_WIDTH    = conv_pkg::DEF_CH_IN_COUNTER_WIDTH;
    localparam int ACC_WIDTH    = conv_pkg::DEF_ACC_WIDTH;
    localparam int TAP_WIDTH    = $clog2(DEPTH);
    localparam int WORDS        = CONV_UNITS + 2;
    localparam int CHANNELS     = 2 ** CH_WIDTH;
    localparam int BP_GROUPS    = 4;                          // Two channels each
    localparam int VECTORS_SENT = 1 + 1 + 3 + 2 * BP_GROUPS + 4;
    localparam int CYCLE_LIMIT  = 40 * VECTORS_SENT + 200;

    typedef logic [CONV_UNITS*ACC_WIDTH-1:0] result_t;
    typedef logic [DATA_WIDTH*WORDS-1:0]     vector_t;
    typedef logic signed [DATA_WIDTH-1:0]    sample_t;

    logic                  aclk;
    logic                  arst_n;
    logic [CNT_WIDTH-1:0]  im_channels_in_1;
    vector_t               s_axis_tdata;
    logic                  s_axis_tvalid;
    logic                  s_axis_tready;
    logic                  s_axis_tlast;
    result_t               m_axis_tdata;
    logic                  m_axis_tvalid;
    logic                  m_axis_tready;
    logic                  m_axis_tlast;
    logic                  weight_wr;
    logic [CH_WIDTH-1:0]   weight_channel;
    logic [TAP_WIDTH-1:0]  weight_tap;
    sample_t               weight_data;

    int      error_count = 0;
    int      test_count  = 0;
    int      cycle_count = 0;
    result_t expected_q [$];  // Results in group order

    `include "conv_tb_model.svh"

    conv_row_engine uut (.*);

    always #50 aclk = ~aclk;

    // Watchdog on total run length
    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge aclk);
        #10;  // Drive point after the edge
    endtask

    task automatic write_weight(input int ch, input int tap, input sample_t value);
        weight_wr        = 1'b1;
        weight_channel   = CH_WIDTH'(ch);
        weight_tap       = TAP_WIDTH'(tap);
        weight_data      = value;
        w_model[ch][tap] = value;
        next_cycle();
        weight_wr = 1'b0;
    endtask

    task automatic random_kernel(input int channels);
        logic [63:0] bits;
        for (int c = 0; c < channels; c++) begin
            for (int k = 0; k < DEPTH; k++) begin
                bits = lfsr_bits(DATA_WIDTH);
                write_weight(c, k, bits[DATA_WIDTH-1:0]);
            end
        end
    endtask

    task automatic send_vector(input vector_t data, input logic last);
        logic ready_seen;
        s_axis_tdata  = data;
        s_axis_tvalid = 1'b1;
        s_axis_tlast  = last;
        ready_seen    = 1'b0;
        while (!ready_seen) begin
            ready_seen = s_axis_tready;  // Registered, stable here
            next_cycle();
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    // Throttled mode draws tready from the LFSR every cycle
    task automatic receive_result(output result_t data, output logic last, input bit throttle);
        logic        done;
        logic [63:0] bits;
        done = 1'b0;
        while (!done) begin
            if (throttle) begin
                bits          = lfsr_bits(1);
                m_axis_tready = bits[0];
            end else begin
                m_axis_tready = 1'b1;
            end
            if (m_axis_tvalid && m_axis_tready) begin
                data = m_axis_tdata;
                last = m_axis_tlast;
                done = 1'b1;
            end
            next_cycle();
        end
        m_axis_tready = 1'b0;
    endtask

    task automatic expect_no_result(input int cycles);
        logic seen;
        seen          = 1'b0;
        m_axis_tready = 1'b1;
        repeat (cycles) begin
            seen = seen | m_axis_tvalid;
            next_cycle();
        end
        m_axis_tready = 1'b0;
        check_flag("m_axis_tvalid after last result", seen, 1'b0);
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        check_flag("s_axis_tready", s_axis_tready, 1'b1);
        check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_flag("m_axis_tlast", m_axis_tlast, 1'b0);
        end_test("reset_state", errors_before);
    endtask

    task automatic test_identity_kernel();
        int      errors_before;
        vector_t v;
        result_t got;
        result_t exp;
        logic    last;
        longint  x;
        errors_before    = error_count;
        im_channels_in_1 = '0;
        write_weight(0, 0, sample_t'(1));
        write_weight(0, 1, sample_t'(0));
        write_weight(0, 2, sample_t'(0));
        v = random_vector();
        for (int i = 0; i < CONV_UNITS; i++) begin
            x = sample_at(v, i);
            exp[i*ACC_WIDTH +: ACC_WIDTH] = x[ACC_WIDTH-1:0];  // Sample i, sign extended
        end
        send_vector(v, 1'b0);
        receive_result(got, last, 1'b0);
        check_result("m_axis_tdata", got, exp);
        check_flag("m_axis_tlast", last, 1'b0);
        end_test("identity_kernel", errors_before);
    endtask

    task automatic test_full_kernel();
        int      errors_before;
        result_t got;
        logic    last;
        errors_before    = error_count;
        im_channels_in_1 = '0;
        random_kernel(1);
        group_vecs[0] = random_vector();
        send_vector(group_vecs[0], 1'b0);
        receive_result(got, last, 1'b0);
        check_result("m_axis_tdata", got, expected_result(1));
        check_flag("m_axis_tlast", last, 1'b0);
        end_test("full_kernel", errors_before);
    endtask

    task automatic test_multi_channel();
        int      errors_before;
        result_t got;
        logic    last;
        errors_before    = error_count;
        im_channels_in_1 = CNT_WIDTH'(2);  // Three channels
        random_kernel(3);
        for (int c = 0; c < 3; c++) begin
            group_vecs[c] = random_vector();
            send_vector(group_vecs[c], 1'b0);
        end
        receive_result(got, last, 1'b0);
        check_result("m_axis_tdata", got, expected_result(3));
        check_flag("m_axis_tlast", last, 1'b0);
        expect_no_result(12);
        end_test("multi_channel", errors_before);
    endtask

    task automatic test_back_pressure();
        int      errors_before;
        vector_t bp_vecs [BP_GROUPS][2];
        result_t got;
        logic    last;
        errors_before    = error_count;
        im_channels_in_1 = CNT_WIDTH'(1);
        random_kernel(2);
        expected_q.delete();
        for (int g = 0; g < BP_GROUPS; g++) begin
            for (int c = 0; c < 2; c++) begin
                bp_vecs[g][c] = random_vector();
                group_vecs[c] = bp_vecs[g][c];
            end
            expected_q.push_back(expected_result(2));
        end
        fork
            for (int g = 0; g < BP_GROUPS; g++) begin
                send_vector(bp_vecs[g][0], 1'b0);
                send_vector(bp_vecs[g][1], 1'b0);
            end
            for (int g = 0; g < BP_GROUPS; g++) begin
                receive_result(got, last, 1'b1);
                check_result("m_axis_tdata", got, expected_q.pop_front());
                check_flag("m_axis_tlast", last, 1'b0);
            end
        join
        expect_no_result(12);
        end_test("back_pressure", errors_before);
    endtask

    task automatic test_tlast();
        int      errors_before;
        result_t got;
        logic    last;
        errors_before    = error_count;
        im_channels_in_1 = CNT_WIDTH'(1);
        for (int grp = 0; grp < 2; grp++) begin
            group_vecs[0] = random_vector();
            group_vecs[1] = random_vector();
            send_vector(group_vecs[0], 1'b0);
            send_vector(group_vecs[1], grp == 1);  // Second group ends the stream
            receive_result(got, last, 1'b0);
            check_result("m_axis_tdata", got, expected_result(2));
            check_flag("m_axis_tlast", last, grp == 1);
        end
        end_test("tlast", errors_before);
    endtask

    initial begin
        aclk             = 1'b0;
        arst_n           = 1'b0;
        im_channels_in_1 = '0;
        s_axis_tdata     = '0;
        s_axis_tvalid    = 1'b0;
        s_axis_tlast     = 1'b0;
        m_axis_tready    = 1'b0;
        weight_wr        = 1'b0;
        weight_channel   = '0;
        weight_tap       = '0;
        weight_data      = '0;
        repeat (3) @(posedge aclk);
        #10;
        arst_n = 1'b1;
        next_cycle();
        test_reset_state();
        test_identity_kernel();
        test_full_kernel();
        test_multi_channel();
        test_back_pressure();
        test_tlast();
        $display("Summary: %0d tests, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/conv_row_engine.sv */
`default_nettype none

module conv_row_engine #(
    parameter int DATA_WIDTH          = conv_pkg::DEF_DATA_WIDTH,
    parameter int CONV_UNITS          = conv_pkg::DEF_CONV_UNITS,
    parameter int DEPTH               = conv_pkg::DEF_DEPTH,
    parameter int CH_WIDTH            = conv_pkg::DEF_CH_WIDTH,
    parameter int CH_IN_COUNTER_WIDTH = conv_pkg::DEF_CH_IN_COUNTER_WIDTH,
    parameter int ACC_WIDTH           = conv_pkg::DEF_ACC_WIDTH
) (
    input  logic                                 aclk,
    input  logic                                 arst_n,
    input  logic [CH_IN_COUNTER_WIDTH-1:0]       im_channels_in_1,  // Channels per group, less one
    input  logic [DATA_WIDTH*(CONV_UNITS+2)-1:0] s_axis_tdata,
    input  logic                                 s_axis_tvalid,
    output logic                                 s_axis_tready,
    input  logic                                 s_axis_tlast,
    output logic [CONV_UNITS*ACC_WIDTH-1:0]      m_axis_tdata,
    output logic                                 m_axis_tvalid,
    input  logic                                 m_axis_tready,
    output logic                                 m_axis_tlast,
    input  logic                                 weight_wr,         // Only between groups
    input  logic [CH_WIDTH-1:0]                  weight_channel,
    input  logic [$clog2(DEPTH)-1:0]             weight_tap,
    input  logic signed [DATA_WIDTH-1:0]         weight_data
);

    logic [$clog2(DEPTH)-1:0]     tap;         // Tap of the beat on the window
    logic [CH_WIDTH-1:0]          rd_channel;
    logic signed [DATA_WIDTH-1:0] rd_weight;

    // Windows from the shift buffer to the MAC lanes
    axis_stream_if #(.WIDTH(DATA_WIDTH * CONV_UNITS)) window_stream ();

    conv_weight_store #(
        .DATA_WIDTH (DATA_WIDTH),
        .DEPTH      (DEPTH),
        .CH_WIDTH   (CH_WIDTH)
    ) weights (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .weight_wr      (weight_wr),
        .weight_channel (weight_channel),
        .weight_tap     (weight_tap),
        .weight_data    (weight_data),
        .rd_channel     (rd_channel),
        .rd_tap         (tap),
        .rd_weight      (rd_weight)
    );

    axis_shift_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .CONV_UNITS (CONV_UNITS),
        .DEPTH      (DEPTH)
    ) shift_buf (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tdata  (s_axis_tdata),
        .s_tvalid (s_axis_tvalid),
        .s_tready (s_axis_tready),
        .s_tlast  (s_axis_tlast),
        .window   (window_stream.source),
        .tap      (tap)
    );

    conv_mac_array #(
        .DATA_WIDTH          (DATA_WIDTH),
        .CONV_UNITS          (CONV_UNITS),
        .DEPTH               (DEPTH),
        .CH_WIDTH            (CH_WIDTH),
        .CH_IN_COUNTER_WIDTH (CH_IN_COUNTER_WIDTH),
        .ACC_WIDTH           (ACC_WIDTH)
    ) mac (
        .aclk             (aclk),
        .arst_n           (arst_n),
        .im_channels_in_1 (im_channels_in_1),
        .window           (window_stream.sink),
        .tap              (tap),
        .rd_channel       (rd_channel),
        .rd_weight        (rd_weight),
        .m_tdata          (m_axis_tdata),
        .m_tvalid         (m_axis_tvalid),
        .m_tready         (m_axis_tready),
        .m_tlast          (m_axis_tlast)
    );

endmodule

`default_nettype wire

/* hw/conv_mac_array.sv */
`default_nettype none

module conv_mac_array #(
    parameter int DATA_WIDTH          = 16,
    parameter int CONV_UNITS          = 8,
    parameter int DEPTH               = 3,
    parameter int CH_WIDTH            = 2,
    parameter int CH_IN_COUNTER_WIDTH = 10,
    parameter int ACC_WIDTH           = 40
) (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic [CH_IN_COUNTER_WIDTH-1:0] im_channels_in_1,
    axis_stream_if.sink                    window,
    input  logic [$clog2(DEPTH)-1:0]       tap,
    output logic [CH_WIDTH-1:0]            rd_channel,
    input  logic signed [DATA_WIDTH-1:0]   rd_weight,
    output logic [CONV_UNITS*ACC_WIDTH-1:0] m_tdata,
    output logic                           m_tvalid,
    input  logic                           m_tready,
    output logic                           m_tlast
);

    localparam logic [$clog2(DEPTH)-1:0] LAST_TAP = ($clog2(DEPTH))'(DEPTH - 1);

    conv_pkg::mac_phase_e           phase;
    logic [CH_IN_COUNTER_WIDTH-1:0] ch_count;    // Channel of the current beat
    logic                           last_seen;   // Sticky tlast within a group
    logic                           m_last_q;
    logic                           beat;
    logic                           accept;
    logic                           last_tap;
    logic                           last_ch;
    logic signed [DATA_WIDTH-1:0]   sample  [CONV_UNITS];
    logic signed [2*DATA_WIDTH-1:0] product [CONV_UNITS];
    logic signed [ACC_WIDTH-1:0]    acc     [CONV_UNITS];

    assign window.tready = (phase == conv_pkg::ACCUMULATE);  // Stall upstream in HOLD

    assign beat     = window.tvalid && window.tready;
    assign accept   = m_tvalid && m_tready;
    assign last_tap = (tap == LAST_TAP);
    assign last_ch  = (ch_count == im_channels_in_1);

    assign rd_channel = ch_count[CH_WIDTH-1:0];  // Store holds 2**CH_WIDTH rows

    // One shared weight per beat, one sample per lane
    always_comb begin
        for (int i = 0; i < CONV_UNITS; i++) begin
            sample[i]  = window.tdata[i*DATA_WIDTH +: DATA_WIDTH];
            product[i] = rd_weight * sample[i];  // Full-width signed product
        end
    end

    // Phase, channel count and group tlast
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= conv_pkg::ACCUMULATE;
            ch_count  <= '0;
            last_seen <= 1'b0;
            m_last_q  <= 1'b0;
        end else if (accept) begin
            phase    <= conv_pkg::ACCUMULATE;  // Result gone, next group
            m_last_q <= 1'b0;
        end else if (beat && last_tap) begin
            if (last_ch) begin
                phase     <= conv_pkg::HOLD;
                ch_count  <= '0;
                last_seen <= 1'b0;
                m_last_q  <= last_seen || window.tlast;
            end else begin
                ch_count  <= ch_count + 1'b1;
                last_seen <= last_seen || window.tlast;
            end
        end
    end

    // Accumulators clear with the accepted result
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < CONV_UNITS; i++) begin
                acc[i] <= '0;
            end
        end else if (accept) begin
            for (int i = 0; i < CONV_UNITS; i++) begin
                acc[i] <= '0;
            end
        end else if (beat) begin
            for (int i = 0; i < CONV_UNITS; i++) begin
                acc[i] <= acc[i] + product[i];  // Sign-extended, wraps at ACC_WIDTH
            end
        end
    end

    // Result presented straight from the accumulators
    always_comb begin
        for (int i = 0; i < CONV_UNITS; i++) begin
            m_tdata[i*ACC_WIDTH +: ACC_WIDTH] = acc[i];
        end
    end

    assign m_tvalid = (phase == conv_pkg::HOLD);
    assign m_tlast  = m_last_q;

    // No beat reaches a held result before it is taken
    property p_result_held;
        @(posedge aclk) disable iff (!arst_n)
            (m_tvalid && !m_tready)
                |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast));
    endproperty

    a_result_held: assert property (p_result_held)
        else $error("held result changed before it was taken");

endmodule

`default_nettype wire

/* hw/axis_shift_buffer.sv */
`default_nettype none

module axis_shift_buffer #(
    parameter int DATA_WIDTH = 16,
    parameter int CONV_UNITS = 8,
    parameter int DEPTH      = 3
) (
    input  logic                                 aclk,
    input  logic                                 arst_n,
    input  logic [DATA_WIDTH*(CONV_UNITS+2)-1:0] s_tdata,
    input  logic                                 s_tvalid,
    output logic                                 s_tready,
    input  logic                                 s_tlast,
    axis_stream_if.source                        window,
    output logic [$clog2(DEPTH)-1:0]             tap
);

    localparam int WORDS       = CONV_UNITS + 2;  // Three-tap window over the row
    localparam int STATE_WIDTH = $clog2(DEPTH);
    localparam logic [STATE_WIDTH-1:0] LAST_STATE = STATE_WIDTH'(DEPTH - 1);

    logic                   insert;      // Input vector taken
    logic                   remove;      // Window beat taken
    logic [STATE_WIDTH-1:0] state;
    logic [STATE_WIDTH-1:0] state_next;
    logic                   valid_q;
    logic                   valid_next;
    logic                   s_ready_q;
    logic                   s_last_q;    // Input tlast of the loaded vector
    logic                   m_last_q;
    logic [DATA_WIDTH-1:0]  s_word [WORDS];
    logic [DATA_WIDTH-1:0]  data_q [WORDS];

    assign insert = s_tvalid && s_ready_q;
    assign remove = valid_q && window.tready;

    assign s_tready      = s_ready_q;
    assign window.tvalid = valid_q;
    assign window.tlast  = m_last_q;

    // State names the beat going into the data registers
    // State 0 loads a vector, states 1..DEPTH-1 shift it down one word
    always_comb begin
        case (state)
            '0:         state_next = STATE_WIDTH'(insert);
            LAST_STATE: state_next = '0;  // Wraps once the next-to-last beat leaves
            default:    state_next = state + STATE_WIDTH'(remove);
        endcase
    end

    // Beat on display lags the state by one
    assign tap = (state == '0) ? LAST_STATE : state - 1'b1;

    // Window valid from load until the last beat leaves
    always_comb begin
        valid_next = valid_q;
        if (insert) begin
            valid_next = 1'b1;
        end else if (remove && (state == '0)) begin
            valid_next = 1'b0;  // Tap DEPTH-1 taken, buffer empty
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= '0;
            valid_q   <= 1'b0;
            s_ready_q <= 1'b1;  // Ready for the first vector
            s_last_q  <= 1'b0;
            m_last_q  <= 1'b0;
        end else begin
            if (insert || remove) begin
                state <= state_next;
            end
            valid_q <= valid_next;
            // Registered ready, only with an empty buffer and a free consumer
            s_ready_q <= !valid_next && window.tready;
            if (insert) begin
                s_last_q <= s_tlast;
            end
            if (remove) begin
                m_last_q <= (state == LAST_STATE) ? s_last_q : 1'b0;  // Last tap only
            end
        end
    end

    for (genvar g = 0; g < WORDS; g++) begin : g_unpack
        assign s_word[g] = s_tdata[g*DATA_WIDTH +: DATA_WIDTH];
    end

    // Payload, no reset
    always_ff @(posedge aclk) begin
        if (insert) begin
            for (int i = 0; i < WORDS; i++) begin
                data_q[i] <= s_word[i];
            end
        end else if (remove && (state != '0)) begin
            // Slide one sample toward lane 0, top word kept
            for (int i = 0; i < WORDS - 1; i++) begin
                data_q[i] <= data_q[i+1];
            end
        end
    end

    // Lower CONV_UNITS words form the window
    always_comb begin
        for (int i = 0; i < CONV_UNITS; i++) begin
            window.tdata[i*DATA_WIDTH +: DATA_WIDTH] = data_q[i];
        end
    end

    // Stalled beat keeps its samples and its tap
    property p_window_stable;
        @(posedge aclk) disable iff (!arst_n)
            (window.tvalid && !window.tready)
                |=> (window.tvalid && $stable(window.tdata) && $stable(tap));
    endproperty

    a_window_stable: assert property (p_window_stable)
        else $error("window beat changed while stalled");

endmodule

`default_nettype wire

/* hw/conv_weight_store.sv */
`default_nettype none

module conv_weight_store #(
    parameter int DATA_WIDTH = 16,
    parameter int DEPTH      = 3,
    parameter int CH_WIDTH   = 2
) (
    input  logic                         aclk,
    input  logic                         arst_n,
    input  logic                         weight_wr,
    input  logic [CH_WIDTH-1:0]          weight_channel,
    input  logic [$clog2(DEPTH)-1:0]     weight_tap,
    input  logic signed [DATA_WIDTH-1:0] weight_data,
    input  logic [CH_WIDTH-1:0]          rd_channel,
    input  logic [$clog2(DEPTH)-1:0]     rd_tap,
    output logic signed [DATA_WIDTH-1:0] rd_weight
);

    localparam int CHANNELS = 2 ** CH_WIDTH;

    // One kernel row per channel
    logic signed [DATA_WIDTH-1:0] weights [CHANNELS][DEPTH];

    // Single write port, loaded between groups
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < CHANNELS; c++) begin
                for (int k = 0; k < DEPTH; k++) begin
                    weights[c][k] <= '0;  // All-zero kernel after reset
                end
            end
        end else if (weight_wr && (weight_tap < DEPTH)) begin
            weights[weight_channel][weight_tap] <= weight_data;
        end
    end

    // Combinational read, shared by every lane
    // Unused tap codes read as zero
    assign rd_weight = (rd_tap < DEPTH) ? weights[rd_channel][rd_tap] : '0;

    // Tap codes at or above DEPTH address nothing
    property p_tap_in_range;
        @(posedge aclk) disable iff (!arst_n)
            weight_wr |-> (weight_tap < DEPTH);
    endproperty

    a_tap_in_range: assert property (p_tap_in_range)
        else $error("weight write to tap %0d, only %0d taps", weight_tap, DEPTH);

endmodule

`default_nettype wire

/* hw/axis_stream_if.sv */
`default_nettype none

// Valid/ready stream, one transfer per cycle with tvalid and tready high
interface axis_stream_if #(
    parameter int WIDTH = 32
) ();

    logic [WIDTH-1:0] tdata;   // Held stable while stalled
    logic             tvalid;
    logic             tready;
    logic             tlast;   // End of a group

    // Producer side
    modport source (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    // Consumer side
    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // Default sizes, overridden per instance from the top level
    localparam int DEF_DATA_WIDTH          = 16;  // Signed sample and weight width
    localparam int DEF_CONV_UNITS          = 8;   // Output lanes per row
    localparam int DEF_DEPTH               = 3;   // Kernel taps
    localparam int DEF_CH_WIDTH            = 2;   // Up to 4 stored channels
    localparam int DEF_CH_IN_COUNTER_WIDTH = 10;
    localparam int DEF_ACC_WIDTH           = 40;  // Wraps, no saturation

    // Phase of the MAC array
    // ACCUMULATE takes window beats
    // HOLD presents a finished result until it is accepted
    typedef enum logic {
        ACCUMULATE = 1'b0,
        HOLD       = 1'b1
    } mac_phase_e;

endpackage

`default_nettype wire
